//--- filelist.f
source/sd_cmd_pkg.sv
source/sd_cmd_ctrl_if.sv
source/sd_crc7.sv
source/sd_cmd_serializer.sv
source/sd_cmd_deserializer.sv
source/sd_cmd_phy.sv
source/sd_cmd_regs.sv
source/sd_cmd_top.sv
dv/sd_cmd_tb.sv

//--- Bender.yml
package:
  name: sd_cmd

sources:
  - source/sd_cmd_pkg.sv
  - source/sd_cmd_ctrl_if.sv
  - source/sd_crc7.sv
  - source/sd_cmd_serializer.sv
  - source/sd_cmd_deserializer.sv
  - source/sd_cmd_phy.sv
  - source/sd_cmd_regs.sv
  - source/sd_cmd_top.sv
  - target: test
    files:
      - dv/sd_cmd_tb.sv

//--- dv/sd_cmd_tb.sv
module sd_cmd_tb import sd_cmd_pkg::*; ;

	localparam int TIMEOUT_CYCLES = 500;
	localparam int MODE_OK = 0;
	localparam int MODE_SILENT = 1;
	localparam int MODE_BAD_CRC = 2;
	localparam int WAIT_OE = 0;
	localparam int WAIT_IRQ = 1;

	logic CLK;
	logic reset;
	logic reg_wr;
	sd_reg_addr_t reg_addr;
	logic [CMD_ARG_W-1:0] reg_wdata;
	logic [CMD_ARG_W-1:0] reg_rdata;
	logic irq;
	logic cmd_in;
	logic cmd_out;
	logic cmd_oe;

	logic [15:0] lfsr = 16'd50;
	int errors;
	int oe_cycles;
	logic [CMD_FRAME_W-1:0] tx_frame;

	sd_cmd_top #(
		.RESP_TIMEOUT(64)
	) uut (
		.CLK(CLK),
		.reset(reset),
		.reg_wr(reg_wr),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_rdata(reg_rdata),
		.irq(irq),
		.cmd_in(cmd_in),
		.cmd_out(cmd_out),
		.cmd_oe(cmd_oe)
	);

	always #2 CLK = ~CLK;

	// card side of the line, collects the command frame
	always @(negedge CLK) begin
		if (cmd_oe) begin
			tx_frame = {tx_frame[CMD_FRAME_W-2:0], cmd_out};
			oe_cycles = oe_cycles + 1;
		end
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// remainder of body * x^7 divided by x^7 + x^3 + 1
	function automatic logic [CRC7_W-1:0] crc7_ref(input logic [39:0] body);
		logic [46:0] rem;
		rem = {body, 7'b0};
		for (int i = 46; i >= 7; i--) begin
			if (rem[i]) begin
				rem[i -: 8] = rem[i -: 8] ^ 8'h89;
			end
		end
		return rem[6:0];
	endfunction

	function automatic logic [CMD_FRAME_W-1:0] frame_ref(input logic trans,
			input logic [CMD_INDEX_W-1:0] index, input logic [CMD_ARG_W-1:0] arg);
		logic [39:0] body;
		body = {1'b0, trans, index, arg};
		return {body, crc7_ref(body), 1'b1};
	endfunction

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s (got 0x%0h, expected 0x%0h)",
				$time, what, actual, expected);
			errors++;
		end
	endtask

	task automatic wait_for(input int sel, input logic level, input string what);
		int n;
		logic seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n < TIMEOUT_CYCLES) begin
			@(negedge CLK);
			seen = (sel == WAIT_OE) ? (cmd_oe === level) : (irq === level);
			n++;
		end
		if (!seen) begin
			$display("timeout at %0t: waited %0d cycles for %s", $time, TIMEOUT_CYCLES, what);
			errors++;
		end
	endtask

	task automatic write_reg(input sd_reg_addr_t addr, input logic [31:0] data);
		@(posedge CLK);
		reg_wr <= 1'b1;
		reg_addr <= addr;
		reg_wdata <= data;
		@(posedge CLK);
		reg_wr <= 1'b0;
	endtask

	task automatic read_reg(input sd_reg_addr_t addr, output logic [31:0] data);
		@(posedge CLK);
		reg_addr <= addr;
		@(negedge CLK);
		data = reg_rdata;
	endtask

	task automatic send_response(input logic [CMD_FRAME_W-1:0] frame);
		for (int i = CMD_FRAME_W - 1; i >= 0; i--) begin
			@(posedge CLK);
			cmd_in <= frame[i];
		end
		@(posedge CLK);
		cmd_in <= 1'b1;
	endtask

	task automatic run_command(input int mode, input logic write_while_busy);
		logic [31:0] index;
		logic [31:0] arg;
		logic [31:0] payload;
		logic [31:0] delay;
		logic [31:0] data;
		logic [31:0] exp_status;
		logic [CMD_FRAME_W-1:0] resp;
		random_bits(6, index);
		random_bits(32, arg);
		random_bits(32, payload);
		random_bits(6, delay);
		tx_frame = '0;
		oe_cycles = 0;
		write_reg(REG_ARG, arg);
		write_reg(REG_CMD, index);
		wait_for(WAIT_OE, 1'b1, "cmd_oe to rise");
		if (write_while_busy) begin
			write_reg(REG_CMD, index ^ 32'h3f);
		end
		wait_for(WAIT_OE, 1'b0, "cmd_oe to fall");
		check_value(tx_frame, frame_ref(1'b1, index[5:0], arg), "command frame");
		if (mode != MODE_SILENT) begin
			resp = frame_ref(1'b0, index[5:0], payload);
			// flip the lowest crc bit
			if (mode == MODE_BAD_CRC) begin
				resp[1] = ~resp[1];
			end
			repeat (2 + delay % 39) @(posedge CLK);
			send_response(resp);
		end
		wait_for(WAIT_IRQ, 1'b1, "irq to rise");
		// room for a second frame that must not appear
		repeat (8) @(posedge CLK);
		check_value(oe_cycles, CMD_FRAME_W, "cmd_oe cycles per transaction");
		case (mode)
			MODE_SILENT: exp_status = 32'h6;
			MODE_BAD_CRC: exp_status = 32'ha;
			default: exp_status = 32'h2;
		endcase
		read_reg(REG_STATUS, data);
		check_value(data, exp_status, "status after transaction");
		if (mode == MODE_OK) begin
			read_reg(REG_RESP_INDEX, data);
			check_value(data, index, "response index");
			read_reg(REG_RESP_ARG, data);
			check_value(data, payload, "response payload");
		end
		write_reg(REG_STATUS, 32'h0);
		@(negedge CLK);
		check_value(irq, 1'b0, "irq after status clear");
		read_reg(REG_STATUS, data);
		check_value(data, 32'h0, "status after clear");
	endtask

	initial begin
		logic [31:0] data;
		CLK = 1'b0;
		reset = 1'b1;
		reg_wr = 1'b0;
		reg_addr = REG_ARG;
		reg_wdata = '0;
		cmd_in = 1'b1;
		errors = 0;
		oe_cycles = 0;
		tx_frame = '0;
		repeat (5) @(posedge CLK);
		reset <= 1'b0;
		@(negedge CLK);
		check_value(cmd_oe, 1'b0, "cmd_oe after reset");
		check_value(irq, 1'b0, "irq after reset");
		check_value(cmd_out, 1'b1, "cmd_out after reset");
		read_reg(REG_STATUS, data);
		check_value(data, 32'h0, "status after reset");

		for (int i = 0; i < 4; i++) begin
			run_command(MODE_OK, 1'b0);
		end
		run_command(MODE_SILENT, 1'b0);
		run_command(MODE_BAD_CRC, 1'b0);
		run_command(MODE_OK, 1'b1);

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- source/sd_cmd_top.sv
module sd_cmd_top import sd_cmd_pkg::*; #(
	parameter int RESP_TIMEOUT = 64
) (
	input logic CLK,
	input logic reset,
	input logic reg_wr,
	input sd_reg_addr_t reg_addr,
	input logic [CMD_ARG_W-1:0] reg_wdata,
	output logic [CMD_ARG_W-1:0] reg_rdata,
	output logic irq,
	input logic cmd_in,
	output logic cmd_out,
	output logic cmd_oe
);

	// command and response exchange
	sd_cmd_ctrl_if ctrl ();

	sd_cmd_regs u_regs (
		.CLK(CLK),
		.reset(reset),
		.reg_wr(reg_wr),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_rdata(reg_rdata),
		.irq(irq),
		.ctrl(ctrl.host)
	);

	sd_cmd_phy #(
		.RESP_TIMEOUT(RESP_TIMEOUT)
	) u_phy (
		.CLK(CLK),
		.reset(reset),
		.ctrl(ctrl.phy),
		.cmd_in(cmd_in),
		.cmd_out(cmd_out),
		.cmd_oe(cmd_oe)
	);

endmodule

//--- source/sd_cmd_regs.sv
module sd_cmd_regs import sd_cmd_pkg::*; (
	input logic CLK,
	input logic reset,
	input logic reg_wr,
	input sd_reg_addr_t reg_addr,
	input logic [CMD_ARG_W-1:0] reg_wdata,
	output logic [CMD_ARG_W-1:0] reg_rdata,
	output logic irq,
	sd_cmd_ctrl_if.host ctrl
);

	logic [CMD_ARG_W-1:0] arg_q;
	logic [CMD_INDEX_W-1:0] cmd_index_q;
	logic [CMD_ARG_W-1:0] resp_arg_q;
	logic [CMD_INDEX_W-1:0] resp_index_q;
	logic busy;
	logic done;
	logic timeout;
	logic crc_error;
	logic cmd_req;
	logic resp_ack;
	logic cmd_write;
	logic resp_take;

	assign cmd_write = reg_wr && (reg_addr == REG_CMD) && !busy && ctrl.idle;
	// ack goes out the cycle after resp_req is seen
	assign resp_take = ctrl.resp_req && !resp_ack;

	always_ff @(posedge CLK) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			timeout <= 1'b0;
			crc_error <= 1'b0;
			cmd_req <= 1'b0;
			resp_ack <= 1'b0;
		end else begin
			resp_ack <= resp_take;
			if (cmd_write) begin
				cmd_req <= 1'b1;
				busy <= 1'b1;
			end else if (ctrl.cmd_ack) begin
				cmd_req <= 1'b0;
			end
			if (reg_wr && reg_addr == REG_STATUS) begin
				done <= 1'b0;
				timeout <= 1'b0;
				crc_error <= 1'b0;
			end
			if (resp_take) begin
				busy <= 1'b0;
				done <= 1'b1;
				timeout <= ctrl.timeout;
				crc_error <= ctrl.crc_error;
			end
		end
	end

	// argument stays stable while the request is pending
	always_ff @(posedge CLK) begin
		if (reg_wr && reg_addr == REG_ARG && !cmd_req) begin
			arg_q <= reg_wdata;
		end
		if (cmd_write) begin
			cmd_index_q <= reg_wdata[CMD_INDEX_W-1:0];
		end
		if (resp_take) begin
			resp_index_q <= ctrl.resp_index;
			resp_arg_q <= ctrl.resp_arg;
		end
	end

	always_comb begin
		case (reg_addr)
			REG_ARG: reg_rdata = arg_q;
			REG_CMD: reg_rdata = {{(CMD_ARG_W-CMD_INDEX_W){1'b0}}, cmd_index_q};
			REG_STATUS: reg_rdata = {{(CMD_ARG_W-4){1'b0}}, crc_error, timeout, done, busy};
			REG_RESP_ARG: reg_rdata = resp_arg_q;
			REG_RESP_INDEX: reg_rdata = {{(CMD_ARG_W-CMD_INDEX_W){1'b0}}, resp_index_q};
			default: reg_rdata = '0;
		endcase
	end

	assign ctrl.cmd_req = cmd_req;
	assign ctrl.cmd_index = cmd_index_q;
	assign ctrl.cmd_arg = arg_q;
	assign ctrl.resp_ack = resp_ack;
	assign irq = done;

endmodule

//--- source/sd_cmd_phy.sv
module sd_cmd_phy import sd_cmd_pkg::*; #(
	parameter int RESP_TIMEOUT = 64
) (
	input logic CLK,
	input logic reset,
	sd_cmd_ctrl_if.phy ctrl,
	input logic cmd_in,
	output logic cmd_out,
	output logic cmd_oe
);

	localparam int BODY_W = CMD_FRAME_W - CRC7_W - 1;
	localparam int WAIT_W = $clog2(RESP_TIMEOUT + 1);

	sd_phy_state_t state;

	logic [BODY_W-1:0] body_q;
	logic send_start;
	logic ser_done;
	logic listen;
	logic [CMD_FRAME_W-1:0] des_frame;
	logic des_crc_error;
	logic des_done;
	logic [WAIT_W-1:0] wait_cnt;
	logic [CMD_INDEX_W-1:0] resp_index_q;
	logic [CMD_ARG_W-1:0] resp_arg_q;
	logic timeout_q;
	logic crc_error_q;

	assign listen = (state == ST_WAITING_RESPONSE) || (state == ST_RECEIVING_RESPONSE);

	sd_cmd_serializer u_ser (
		.CLK(CLK),
		.reset(reset),
		.start(send_start),
		.body(body_q),
		.cmd_out(cmd_out),
		.cmd_oe(cmd_oe),
		.done(ser_done)
	);

	sd_cmd_deserializer u_des (
		.CLK(CLK),
		.reset(reset),
		.listen(listen),
		.cmd_in(cmd_in),
		.frame(des_frame),
		.crc_error(des_crc_error),
		.done(des_done)
	);

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= ST_INACTIVE;
			send_start <= 1'b0;
			wait_cnt <= '0;
			timeout_q <= 1'b0;
			crc_error_q <= 1'b0;
		end else begin
			send_start <= 1'b0;
			unique case (state)
				ST_INACTIVE: begin
					if (ctrl.cmd_req) begin
						state <= ST_SETUP;
					end
				end
				ST_SETUP: begin
					// start bit 0, transmission bit 1
					if (ctrl.cmd_req) begin
						body_q <= {2'b01, ctrl.cmd_index, ctrl.cmd_arg};
						send_start <= 1'b1;
						state <= ST_SENDING;
					end
				end
				ST_SENDING: begin
					wait_cnt <= '0;
					if (ser_done) begin
						state <= ST_WAITING_RESPONSE;
					end
				end
				ST_WAITING_RESPONSE: begin
					if (!cmd_in) begin
						state <= ST_RECEIVING_RESPONSE;
					end else if (wait_cnt == WAIT_W'(RESP_TIMEOUT - 1)) begin
						resp_index_q <= '0;
						resp_arg_q <= '0;
						timeout_q <= 1'b1;
						crc_error_q <= 1'b0;
						state <= ST_RETURN_RESPONSE;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				ST_RECEIVING_RESPONSE: begin
					if (des_done) begin
						resp_index_q <= des_frame[CMD_FRAME_W-3 -: CMD_INDEX_W];
						resp_arg_q <= des_frame[BODY_W-1 -: CMD_ARG_W];
						timeout_q <= 1'b0;
						crc_error_q <= des_crc_error;
						state <= ST_RETURN_RESPONSE;
					end
				end
				ST_RETURN_RESPONSE: begin
					if (ctrl.resp_ack) begin
						state <= ST_INACTIVE;
					end
				end
				default: state <= ST_INACTIVE;
			endcase
		end
	end

	assign ctrl.cmd_ack = (state == ST_SETUP) && ctrl.cmd_req;
	assign ctrl.resp_req = (state == ST_RETURN_RESPONSE);
	assign ctrl.resp_index = resp_index_q;
	assign ctrl.resp_arg = resp_arg_q;
	assign ctrl.timeout = timeout_q;
	assign ctrl.crc_error = crc_error_q;
	assign ctrl.idle = (state == ST_INACTIVE);

endmodule

//--- source/sd_cmd_deserializer.sv
module sd_cmd_deserializer import sd_cmd_pkg::*; (
	input logic CLK,
	input logic reset,
	input logic listen,
	input logic cmd_in,
	output logic [CMD_FRAME_W-1:0] frame,
	output logic crc_error,
	output logic done
);

	// crc covers start bit through the last payload bit
	localparam int CHECK_W = CMD_FRAME_W - CRC7_W - 1;

	logic active;
	logic [$clog2(CMD_FRAME_W)-1:0] count;
	logic [CRC7_W-1:0] crc;
	logic begin_frame;
	logic last_bit;
	logic crc_en;
	logic crc_clear;

	assign begin_frame = listen && !active && !cmd_in;
	assign last_bit = active && count == CMD_FRAME_W - 1;
	assign crc_en = begin_frame || (active && count < CHECK_W);
	assign crc_clear = last_bit || !listen;

	sd_crc7 u_crc (
		.CLK(CLK),
		.reset(reset),
		.clear(crc_clear),
		.enable(crc_en),
		.data_bit(cmd_in),
		.crc(crc)
	);

	always_ff @(posedge CLK) begin
		if (reset) begin
			active <= 1'b0;
			count <= '0;
			crc_error <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (!listen) begin
				active <= 1'b0;
			end else if (begin_frame) begin
				active <= 1'b1;
				count <= 1;
			end else if (active) begin
				count <= count + 1'b1;
				if (last_bit) begin
					active <= 1'b0;
					done <= 1'b1;
					// received crc sits in the low bits, end bit is on the line now
					crc_error <= (frame[CRC7_W-1:0] != crc) || frame[CMD_FRAME_W-3] || !cmd_in;
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (begin_frame) begin
			frame <= {{(CMD_FRAME_W-1){1'b0}}, cmd_in};
		end else if (active) begin
			frame <= {frame[CMD_FRAME_W-2:0], cmd_in};
		end
	end

endmodule

//--- source/sd_cmd_serializer.sv
module sd_cmd_serializer import sd_cmd_pkg::*; (
	input logic CLK,
	input logic reset,
	input logic start,
	input logic [CMD_FRAME_W-CRC7_W-2:0] body,
	output logic cmd_out,
	output logic cmd_oe,
	output logic done
);

	localparam int BODY_W = CMD_FRAME_W - CRC7_W - 1;

	logic active;
	logic [$clog2(CMD_FRAME_W+1)-1:0] count;
	logic [BODY_W-1:0] shift;
	logic [CRC7_W-1:0] crc;
	logic load;
	logic crc_bit;
	logic crc_en;
	logic crc_clear;

	assign load = start && !active;
	assign crc_bit = active ? shift[BODY_W-1] : body[BODY_W-1];
	assign crc_en = load || (active && count < BODY_W);
	assign crc_clear = active && count == CMD_FRAME_W;

	sd_crc7 u_crc (
		.CLK(CLK),
		.reset(reset),
		.clear(crc_clear),
		.enable(crc_en),
		.data_bit(crc_bit),
		.crc(crc)
	);

	// count holds the number of bits already on the line
	always_ff @(posedge CLK) begin
		if (reset) begin
			active <= 1'b0;
			count <= '0;
			cmd_out <= 1'b1;
			cmd_oe <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (load) begin
				active <= 1'b1;
				count <= 1;
				cmd_oe <= 1'b1;
				cmd_out <= body[BODY_W-1];
			end else if (active) begin
				if (count == CMD_FRAME_W) begin
					active <= 1'b0;
					count <= '0;
					cmd_oe <= 1'b0;
					cmd_out <= 1'b1;
					done <= 1'b1;
				end else begin
					count <= count + 1'b1;
					cmd_out <= (count == BODY_W) ? crc[CRC7_W-1] : shift[BODY_W-1];
				end
			end
		end
	end

	// body bits, then remaining crc bits followed by the end bit
	always_ff @(posedge CLK) begin
		if (load) begin
			shift <= {body[BODY_W-2:0], 1'b0};
		end else if (active) begin
			if (count == BODY_W) begin
				shift <= {crc[CRC7_W-2:0], 1'b1, {(BODY_W-CRC7_W){1'b0}}};
			end else begin
				shift <= shift << 1;
			end
		end
	end

endmodule

//--- source/sd_crc7.sv
module sd_crc7 import sd_cmd_pkg::*; (
	input logic CLK,
	input logic reset,
	input logic clear,
	input logic enable,
	input logic data_bit,
	output logic [CRC7_W-1:0] crc
);

	// x^7 + x^3 + 1
	localparam logic [CRC7_W-1:0] CRC7_POLY = 7'h09;

	logic feedback;

	assign feedback = data_bit ^ crc[CRC7_W-1];

	always_ff @(posedge CLK) begin
		if (reset || clear) begin
			crc <= '0;
		end else if (enable) begin
			crc <= {crc[CRC7_W-2:0], 1'b0} ^ ({CRC7_W{feedback}} & CRC7_POLY);
		end
	end

endmodule

//--- source/sd_cmd_ctrl_if.sv
interface sd_cmd_ctrl_if import sd_cmd_pkg::*; ();

	// command direction
	logic cmd_req;
	logic cmd_ack;
	logic [CMD_INDEX_W-1:0] cmd_index;
	logic [CMD_ARG_W-1:0] cmd_arg;

	// response direction
	logic resp_req;
	logic resp_ack;
	logic [CMD_INDEX_W-1:0] resp_index;
	logic [CMD_ARG_W-1:0] resp_arg;
	logic timeout;
	logic crc_error;
	logic idle;

	modport host (
		output cmd_req, cmd_index, cmd_arg, resp_ack,
		input cmd_ack, resp_req, resp_index, resp_arg, timeout, crc_error, idle
	);

	modport phy (
		input cmd_req, cmd_index, cmd_arg, resp_ack,
		output cmd_ack, resp_req, resp_index, resp_arg, timeout, crc_error, idle
	);

endinterface

//--- source/sd_cmd_pkg.sv
package sd_cmd_pkg;

	// frame and field widths
	localparam int CMD_FRAME_W = 48;
	localparam int CMD_INDEX_W = 6;
	localparam int CMD_ARG_W = 32;
	localparam int CRC7_W = 7;

	// one-hot sequencer states
	typedef enum logic [5:0] {
		ST_INACTIVE = 6'b000001,
		ST_SETUP = 6'b000010,
		ST_SENDING = 6'b000100,
		ST_WAITING_RESPONSE = 6'b001000,
		ST_RECEIVING_RESPONSE = 6'b010000,
		ST_RETURN_RESPONSE = 6'b100000
	} sd_phy_state_t;

	// register map
	typedef enum logic [2:0] {
		REG_ARG = 3'd0,
		REG_CMD = 3'd1,
		REG_STATUS = 3'd2,
		REG_RESP_ARG = 3'd3,
		REG_RESP_INDEX = 3'd4
	} sd_reg_addr_t;

endpackage
